// ==== build.f ====
common/dmem_pkg.sv
datamem/byte_lane_ram.sv
datamem/store_lane_steer.sv
datamem/load_lane_merge.sv
rtl/fpga_io_regs.sv
rtl/apb_con_bridge.sv
rtl/datamem_top.sv
dv/datamem_assertions.sv
dv/tb_datamem.sv

// ==== common/dmem_pkg.sv ====
package dmem_pkg;

	// Data path widths
	typedef logic [31:0] word_t;
	typedef logic [7:0]  byte_t;

	// One strobe bit per byte lane
	typedef logic [3:0]  strb_t;

	// Core word index
	// Top bit splits RAM from board I/O
	typedef logic [10:0] core_addr_t;

	// APB byte address
	typedef logic [11:0] apb_addr_t;

	localparam int LANES = 4;

	// Index bit that selects the I/O region
	localparam int IO_BIT = 10;

	// Board I/O word indices
	localparam core_addr_t IO_BTN_IDX = 11'h400;
	localparam core_addr_t IO_SW_IDX  = 11'h401;
	localparam core_addr_t IO_LED_IDX = 11'h402;

	// One core access
	// Zero strobe is a load
	typedef struct packed {
		core_addr_t addr;
		strb_t      strb;
		word_t      wdata;
	} core_req_t;

	// Write request for a single byte lane
	typedef struct packed {
		logic  we;
		byte_t data;
	} lane_wr_t;

	// RISC-V store strobes
	// SW, SH low and high, SB on each lane
	function automatic logic strb_legal(strb_t strb);
		case (strb)
			4'b1111, 4'b0011, 4'b1100,
			4'b0001, 4'b0010, 4'b0100, 4'b1000: strb_legal = 1'b1;
			default: strb_legal = 1'b0;
		endcase
	endfunction

endpackage

// ==== datamem/byte_lane_ram.sv ====
`timescale 1ns/1ps

module byte_lane_ram #(
	parameter int RAM_AW = 10
) (
	input  logic                 clk,

	// Port A, core side
	input  logic [RAM_AW-1:0]    a_addr,
	input  dmem_pkg::lane_wr_t   a_wr,
	output dmem_pkg::byte_t      a_rdata,

	// Port B, protocol controller side
	input  logic [RAM_AW-1:0]    b_addr,
	input  dmem_pkg::lane_wr_t   b_wr,
	output dmem_pkg::byte_t      b_rdata
);

	// One byte of every word
	dmem_pkg::byte_t mem [2**RAM_AW];

	// Port A
	// Read returns contents from before the write
	always @(posedge clk) begin
		if (a_wr.we) begin
			mem[a_addr] <= a_wr.data;
		end
		a_rdata <= mem[a_addr];
	end

	// Port B
	// Same read-first behaviour
	always @(posedge clk) begin
		if (b_wr.we) begin
			mem[b_addr] <= b_wr.data;
		end
		b_rdata <= mem[b_addr];
	end

	// Same word written from both ports in one cycle is undefined
	// Block RAM resolves it however it likes

endmodule

// ==== datamem/load_lane_merge.sv ====
`timescale 1ns/1ps

module load_lane_merge (
	input  logic                                    clk,
	input  logic                                    nrst,

	// Address of the load being issued this cycle
	input  dmem_pkg::core_addr_t                    core_addr,

	// Registered bank outputs
	input  dmem_pkg::byte_t [dmem_pkg::LANES-1:0]   a_lane_rdata,
	input  dmem_pkg::byte_t [dmem_pkg::LANES-1:0]   b_lane_rdata,

	// Board I/O registers
	input  dmem_pkg::word_t                         io_btn,
	input  dmem_pkg::word_t                         io_sw,
	input  dmem_pkg::word_t                         io_led,

	output dmem_pkg::word_t                         core_rdata,
	output dmem_pkg::word_t                         con_rdata
);

	dmem_pkg::core_addr_t addr_q;
	logic                 vld_q;
	dmem_pkg::word_t      a_word;

	// Address follows the bank read by one cycle
	// Valid flag keeps the output at zero until the first load returns
	always_ff @(posedge clk) begin
		if (!nrst) begin
			addr_q <= '0;
			vld_q  <= 1'b0;
		end else begin
			addr_q <= core_addr;
			vld_q  <= 1'b1;
		end
	end

	// Lane n lands on bits 8n+7..8n
	assign a_word    = a_lane_rdata;
	assign con_rdata = b_lane_rdata;

	always_comb begin
		if (!vld_q) begin
			core_rdata = '0;
		end else if (!addr_q[dmem_pkg::IO_BIT]) begin
			core_rdata = a_word;
		end else begin
			case (addr_q)
				dmem_pkg::IO_BTN_IDX: core_rdata = io_btn;
				dmem_pkg::IO_SW_IDX:  core_rdata = io_sw;
				dmem_pkg::IO_LED_IDX: core_rdata = io_led;
				// Holes in the I/O map read as zero
				default:              core_rdata = '0;
			endcase
		end
	end

endmodule

// ==== datamem/store_lane_steer.sv ====
`timescale 1ns/1ps

module store_lane_steer #(
	parameter int RAM_AW = 10
) (
	// Core request, presented every cycle
	input  dmem_pkg::core_req_t                        core_req,

	// Already validated by the APB bridge
	input  logic [RAM_AW-1:0]                          con_addr,
	input  dmem_pkg::strb_t                            con_strb,
	input  dmem_pkg::word_t                            con_wdata,
	input  logic                                       con_we,

	// Per-lane RAM requests
	output logic [RAM_AW-1:0]                          a_addr,
	output logic [RAM_AW-1:0]                          b_addr,
	output dmem_pkg::lane_wr_t [dmem_pkg::LANES-1:0]   a_lane_wr,
	output dmem_pkg::lane_wr_t [dmem_pkg::LANES-1:0]   b_lane_wr
);

	logic core_is_io;
	logic core_we;

	// Index wraps to the RAM depth
	assign a_addr = core_req.addr[RAM_AW-1:0];
	assign b_addr = con_addr;

	// I/O stores are handled by the I/O registers
	assign core_is_io = core_req.addr[dmem_pkg::IO_BIT];

	// Unknown strobe patterns drop the store
	// Loads fall out here too since zero is not legal
	assign core_we = dmem_pkg::strb_legal(core_req.strb) && !core_is_io;

	always_comb begin
		for (int i = 0; i < dmem_pkg::LANES; i++) begin
			// Core lane i
			a_lane_wr[i].we   = core_we && core_req.strb[i];
			a_lane_wr[i].data = core_req.wdata[8*i +: 8];

			// Controller lane i
			// Any strobe pattern accepted here
			b_lane_wr[i].we   = con_we && con_strb[i];
			b_lane_wr[i].data = con_wdata[8*i +: 8];
		end
	end

endmodule

// ==== dv/datamem_assertions.sv ====
`timescale 1ns/1ps

module datamem_assertions (
	input logic                 clk,
	input logic                 nrst,
	input logic                 psel,
	input logic                 penable,
	input logic                 pwrite,
	input dmem_pkg::apb_addr_t  paddr,
	input dmem_pkg::word_t      pwdata,
	input logic                 pready,
	input logic                 pslverr,
	input logic [3:0]           led,
	input dmem_pkg::word_t      core_rdata
);

	// Outputs cleared one edge into reset
	reset_values: assert property (@(posedge clk)
		!nrst |=> (!pready && !pslverr && led == 4'h0 && core_rdata == '0))
		else $error("outputs not cleared after a reset edge");

	// Completion lasts a single cycle
	ready_one_cycle: assert property (@(posedge clk) disable iff (!nrst)
		pready |=> !pready)
		else $error("pready held high for more than one cycle");

	// Master holds the transfer while the slave waits
	hold_while_wait: assert property (@(posedge clk) disable iff (!nrst)
		psel && penable && !pready |=>
		psel && penable && $stable(paddr) && $stable(pwrite) && $stable(pwdata))
		else $error("APB signals changed during a wait state");

	// Completion only inside an access phase
	ready_in_access: assert property (@(posedge clk) disable iff (!nrst)
		pready |-> psel && penable)
		else $error("pready raised outside an access phase");

	// Error only on a completing cycle
	err_with_ready: assert property (@(posedge clk) disable iff (!nrst)
		pslverr |-> pready)
		else $error("pslverr raised without pready");

endmodule

// ==== dv/datamem_vectors.txt ====
# columns: op addr data strb expect, all hex; op 1 core store, 2 core load, 3 apb write (expect pslverr)
# op 4 apb read, 5 board inputs (data[3:0] btn, data[6:4] sw), 6 misaligned apb read, 7 led check
# state after reset
7 000 00000000 0 00000000
2 400 00000000 0 00000000
2 401 00000000 0 00000000
2 402 00000000 0 00000000
# core stores of each width, illegal strobes last
1 010 11223344 f 00000000
2 010 00000000 0 11223344
1 010 0000aabb 3 00000000
1 010 ccdd0000 c 00000000
2 010 00000000 0 ccddaabb
1 010 00000055 1 00000000
1 010 00006600 2 00000000
1 010 00770000 4 00000000
1 010 99000000 8 00000000
2 010 00000000 0 99776655
1 010 ffffffff 5 00000000
1 010 ffffffff 7 00000000
2 010 00000000 0 99776655
# both ports share one memory, misaligned addresses rejected
3 080 deadbeef f 00000000
2 020 00000000 0 deadbeef
1 021 cafef00d f 00000000
4 084 00000000 0 cafef00d
3 086 12345678 f 00000001
4 084 00000000 0 cafef00d
6 081 00000000 0 00000001
3 080 0000ab00 2 00000000
2 020 00000000 0 deadabef
# buttons and switches
5 000 00000059 0 00000000
2 400 00000000 0 00000009
2 401 00000000 0 00000005
2 403 00000000 0 00000000
# LED register and the RAM word at the same low index
1 002 01020304 f 00000000
1 402 0000000a 1 00000000
7 000 00000000 0 0000000a
1 402 5a5a0000 c 00000000
2 402 00000000 0 5a5a000a
1 402 00000003 1 00000000
7 000 00000000 0 00000003
2 402 00000000 0 5a5a0003
2 002 00000000 0 01020304
4 008 00000000 0 01020304

// ==== dv/tb_datamem.sv ====
`timescale 1ns/1ps

module tb_datamem;

	localparam int RAM_AW   = 10;
	localparam int VEC_MAX  = 64;
	// Longest wait for pready before the slave counts as hung
	localparam int APB_WAIT = 6;

	// Operation codes of the vector file
	localparam logic [3:0] OP_CORE_WR = 4'h1;
	localparam logic [3:0] OP_CORE_RD = 4'h2;
	localparam logic [3:0] OP_APB_WR  = 4'h3;
	localparam logic [3:0] OP_APB_RD  = 4'h4;
	localparam logic [3:0] OP_BOARD   = 4'h5;
	localparam logic [3:0] OP_APB_BAD = 4'h6;
	localparam logic [3:0] OP_LED     = 4'h7;

	logic                 clk;
	logic                 nrst;
	dmem_pkg::core_req_t  core_req;
	dmem_pkg::word_t      core_rdata;
	logic [3:0]           btn;
	logic [2:0]           sw;
	logic [3:0]           led;
	logic                 psel;
	logic                 penable;
	logic                 pwrite;
	dmem_pkg::apb_addr_t  paddr;
	dmem_pkg::word_t      pwdata;
	dmem_pkg::strb_t      pstrb;
	dmem_pkg::word_t      prdata;
	logic                 pready;
	logic                 pslverr;

	// Operations loaded from the vector file
	logic [3:0]           vec_op   [VEC_MAX];
	logic [11:0]          vec_addr [VEC_MAX];
	dmem_pkg::word_t      vec_data [VEC_MAX];
	dmem_pkg::strb_t      vec_strb [VEC_MAX];
	dmem_pkg::word_t      vec_exp  [VEC_MAX];
	int                   n_vec;

	int                   errors;
	int                   checks;
	int                   cycle_cnt;
	int                   cycle_limit;
	logic                 test_ok;

	datamem_top #(.RAM_AW(RAM_AW)) DUT (
		.clk        (clk),
		.nrst       (nrst),
		.core_req   (core_req),
		.core_rdata (core_rdata),
		.btn        (btn),
		.sw         (sw),
		.led        (led),
		.psel       (psel),
		.penable    (penable),
		.pwrite     (pwrite),
		.paddr      (paddr),
		.pwdata     (pwdata),
		.pstrb      (pstrb),
		.prdata     (prdata),
		.pready     (pready),
		.pslverr    (pslverr)
	);

	bind datamem_top datamem_assertions u_assertions (
		.clk        (clk),
		.nrst       (nrst),
		.psel       (psel),
		.penable    (penable),
		.pwrite     (pwrite),
		.paddr      (paddr),
		.pwdata     (pwdata),
		.pready     (pready),
		.pslverr    (pslverr),
		.led        (led),
		.core_rdata (core_rdata)
	);

	// 4 ns clock
	always #2 clk = ~clk;

	// Run length guard, limit set once the vectors are known
	always @(posedge clk) begin
		cycle_cnt++;
		if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
			$display("Timeout: run did not finish within %0d cycles", cycle_limit);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	task automatic read_vectors();
		int              fd;
		int              code;
		string           line;
		logic [3:0]      op;
		logic [11:0]     addr;
		dmem_pkg::word_t data;
		dmem_pkg::strb_t strb;
		dmem_pkg::word_t expv;
		n_vec = 0;
		fd = $fopen("dv/datamem_vectors.txt", "r");
		if (fd == 0) begin
			$display("Cannot open dv/datamem_vectors.txt");
		end else begin
			while (!$feof(fd) && n_vec < VEC_MAX) begin
				code = $fgets(line, fd);
				// Hash lines are comments
				if (code > 0 && line.getc(0) != 8'h23) begin
					code = $sscanf(line, "%h %h %h %h %h", op, addr, data, strb, expv);
					if (code == 5) begin
						vec_op[n_vec]   = op;
						vec_addr[n_vec] = addr;
						vec_data[n_vec] = data;
						vec_strb[n_vec] = strb;
						vec_exp[n_vec]  = expv;
						n_vec++;
					end
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic check_word(input string what, input dmem_pkg::word_t got,
		input dmem_pkg::word_t expv);
		checks++;
		assert (got === expv) else begin
			$display("FAILED at %0t: %s is 0x%08h, expected 0x%08h", $time, what, got, expv);
			errors++;
			test_ok = 1'b0;
		end
	endtask

	// Store takes effect at the next edge
	task automatic core_store(input logic [10:0] addr, input dmem_pkg::word_t data,
		input dmem_pkg::strb_t strb);
		core_req.addr  = addr;
		core_req.strb  = strb;
		core_req.wdata = data;
		@(posedge clk);
		#1;
		core_req = '0;
	endtask

	// Data due one cycle after the address
	task automatic core_load(input logic [10:0] addr, input dmem_pkg::word_t expv);
		core_req.addr  = addr;
		core_req.strb  = '0;
		core_req.wdata = '0;
		@(posedge clk);
		#1;
		check_word("core_rdata", core_rdata, expv);
		core_req = '0;
	endtask

	// Full APB transfer, cycles counted from setup to the completing edge
	task automatic apb_transfer(input logic wr, input logic [11:0] addr,
		input dmem_pkg::word_t data, input dmem_pkg::strb_t strb,
		output dmem_pkg::word_t rdata, output logic err, output int cycles);
		int waited;
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = wr;
		paddr   = addr;
		pwdata  = wr ? data : '0;
		pstrb   = wr ? strb : '0;
		@(posedge clk);
		#1;
		cycles  = 1;
		waited  = 0;
		penable = 1'b1;
		while (!pready && waited < APB_WAIT) begin
			@(posedge clk);
			#1;
			cycles++;
			waited++;
		end
		if (!pready) begin
			$display("APB transfer to 0x%03h hung at %0t, pready never rose", addr, $time);
			errors++;
			test_ok = 1'b0;
		end
		rdata = prdata;
		err   = pslverr;
		@(posedge clk);
		#1;
		cycles++;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
		pstrb   = '0;
	endtask

	function automatic string op_name(input logic [3:0] op);
		case (op)
			OP_CORE_WR: op_name = "core store";
			OP_CORE_RD: op_name = "core load";
			OP_APB_WR:  op_name = "apb write";
			OP_APB_RD:  op_name = "apb read";
			OP_BOARD:   op_name = "board inputs";
			OP_APB_BAD: op_name = "apb misaligned read";
			OP_LED:     op_name = "led check";
			default:    op_name = "unknown";
		endcase
	endfunction

	task automatic run_vector(input int idx);
		dmem_pkg::word_t rdata;
		logic            err;
		int              cycles;
		test_ok = 1'b1;
		case (vec_op[idx])
			OP_CORE_WR: core_store(vec_addr[idx][10:0], vec_data[idx], vec_strb[idx]);
			OP_CORE_RD: core_load(vec_addr[idx][10:0], vec_exp[idx]);
			OP_APB_WR: begin
				apb_transfer(1'b1, vec_addr[idx], vec_data[idx], vec_strb[idx],
					rdata, err, cycles);
				check_word("pslverr", 32'(err), 32'(vec_exp[idx][0]));
				check_word("write cycles", 32'(cycles), 32'd2);
			end
			OP_APB_RD: begin
				apb_transfer(1'b0, vec_addr[idx], '0, '0, rdata, err, cycles);
				check_word("prdata", rdata, vec_exp[idx]);
				check_word("pslverr", 32'(err), 32'd0);
				check_word("read cycles", 32'(cycles), 32'd3);
			end
			OP_APB_BAD: begin
				apb_transfer(1'b0, vec_addr[idx], '0, '0, rdata, err, cycles);
				check_word("pslverr", 32'(err), 32'(vec_exp[idx][0]));
				check_word("error cycles", 32'(cycles), 32'd2);
			end
			OP_BOARD: begin
				// Registered once before the core can see it
				btn = vec_data[idx][3:0];
				sw  = vec_data[idx][6:4];
				@(posedge clk);
				#1;
			end
			OP_LED: check_word("led", 32'(led), 32'(vec_exp[idx][3:0]));
			default: begin
				$display("Vector %0d holds unknown operation %h", idx, vec_op[idx]);
				errors++;
				test_ok = 1'b0;
			end
		endcase
		$display("test %0d %s: %s", idx, op_name(vec_op[idx]), test_ok ? "ok" : "error");
	endtask

	initial begin
		$timeformat(-9, 0, " ns", 0);
		clk         = 1'b0;
		nrst        = 1'b0;
		core_req    = '0;
		btn         = '0;
		sw          = '0;
		psel        = 1'b0;
		penable     = 1'b0;
		pwrite      = 1'b0;
		paddr       = '0;
		pwdata      = '0;
		pstrb       = '0;
		errors      = 0;
		checks      = 0;
		cycle_cnt   = 0;
		cycle_limit = 0;
		read_vectors();
		if (n_vec == 0) begin
			$display("No vectors loaded, nothing was run");
			$display("*** TEST FAILED ***");
			$finish;
		end else begin
			cycle_limit = n_vec * 8 + 50;
			// Two reset cycles
			repeat (2) @(posedge clk);
			#1;
			nrst = 1'b1;
			for (int i = 0; i < n_vec; i++) begin
				run_vector(i);
			end
			$display("%0d tests, %0d checks, %0d errors", n_vec, checks, errors);
			if (errors == 0) begin
				$display("*** TEST PASSED ***");
			end else begin
				$display("*** TEST FAILED ***");
			end
			$finish;
		end
	end

endmodule

// ==== rtl/apb_con_bridge.sv ====
`timescale 1ns/1ps

module apb_con_bridge #(
	parameter int RAM_AW = 10
) (
	input  logic                  clk,
	input  logic                  nrst,

	// APB slave
	input  logic                  psel,
	input  logic                  penable,
	input  logic                  pwrite,
	input  dmem_pkg::apb_addr_t   paddr,
	input  dmem_pkg::word_t       pwdata,
	input  dmem_pkg::strb_t       pstrb,
	output logic                  pready,
	output logic                  pslverr,
	output dmem_pkg::word_t       prdata,

	// RAM port B request and returned word
	input  dmem_pkg::word_t       con_rdata,
	output logic [RAM_AW-1:0]     con_addr,
	output dmem_pkg::strb_t       con_strb,
	output dmem_pkg::word_t       con_wdata,
	output logic                  con_we
);

	typedef enum logic [1:0] {
		IDLE,
		ACCESS,
		READ_WAIT
	} state_t;

	state_t state;
	logic   misaligned;

	assign misaligned = (paddr[1:0] != 2'b00);

	// Byte address to word index, wrapped to the RAM depth
	assign con_addr  = RAM_AW'(paddr[11:2]);
	assign con_strb  = pstrb;
	assign con_wdata = pwdata;

	// Write lands at the end of the first access cycle
	// pslverr already marks a bad address there
	assign con_we = (state == ACCESS) && psel && penable && pwrite && !pslverr;

	// Bank output is valid in the wait state
	assign prdata = (state == READ_WAIT) ? con_rdata : '0;

	always_ff @(posedge clk) begin
		if (!nrst) begin
			state   <= IDLE;
			pready  <= 1'b0;
			pslverr <= 1'b0;
		end else begin
			case (state)
				IDLE: begin
					// Setup phase seen
					if (psel && !penable) begin
						state   <= ACCESS;
						// Writes and errors finish in the first access cycle
						pready  <= pwrite || misaligned;
						pslverr <= misaligned;
					end
				end
				ACCESS: begin
					if (pready) begin
						state   <= IDLE;
						pready  <= 1'b0;
						pslverr <= 1'b0;
					end else begin
						// Bank read issued this cycle
						state  <= READ_WAIT;
						pready <= 1'b1;
					end
				end
				READ_WAIT: begin
					state  <= IDLE;
					pready <= 1'b0;
				end
				default: begin
					state   <= IDLE;
					pready  <= 1'b0;
					pslverr <= 1'b0;
				end
			endcase
		end
	end

endmodule

// ==== rtl/datamem_top.sv ====
`timescale 1ns/1ps

module datamem_top #(
	parameter int RAM_AW = 10
) (
	input  logic                  clk,
	input  logic                  nrst,

	// Core load/store port
	input  dmem_pkg::core_req_t   core_req,
	output dmem_pkg::word_t       core_rdata,

	// Board I/O
	input  logic [3:0]            btn,
	input  logic [2:0]            sw,
	output logic [3:0]            led,

	// Protocol controller APB port
	input  logic                  psel,
	input  logic                  penable,
	input  logic                  pwrite,
	input  dmem_pkg::apb_addr_t   paddr,
	input  dmem_pkg::word_t       pwdata,
	input  dmem_pkg::strb_t       pstrb,
	output dmem_pkg::word_t       prdata,
	output logic                  pready,
	output logic                  pslverr
);

	// Bridge to RAM port B
	logic [RAM_AW-1:0] con_addr;
	dmem_pkg::strb_t   con_strb;
	dmem_pkg::word_t   con_wdata;
	dmem_pkg::word_t   con_rdata;
	logic              con_we;

	// Bank ports
	logic [RAM_AW-1:0]                          a_addr;
	logic [RAM_AW-1:0]                          b_addr;
	dmem_pkg::lane_wr_t [dmem_pkg::LANES-1:0]   a_lane_wr;
	dmem_pkg::lane_wr_t [dmem_pkg::LANES-1:0]   b_lane_wr;
	dmem_pkg::byte_t [dmem_pkg::LANES-1:0]      a_lane_rdata;
	dmem_pkg::byte_t [dmem_pkg::LANES-1:0]      b_lane_rdata;

	// I/O register words
	dmem_pkg::word_t io_btn;
	dmem_pkg::word_t io_sw;
	dmem_pkg::word_t io_led;

	apb_con_bridge #(.RAM_AW(RAM_AW)) u_bridge (
		.clk       (clk),
		.nrst      (nrst),
		.psel      (psel),
		.penable   (penable),
		.pwrite    (pwrite),
		.paddr     (paddr),
		.pwdata    (pwdata),
		.pstrb     (pstrb),
		.pready    (pready),
		.pslverr   (pslverr),
		.prdata    (prdata),
		.con_rdata (con_rdata),
		.con_addr  (con_addr),
		.con_strb  (con_strb),
		.con_wdata (con_wdata),
		.con_we    (con_we)
	);

	store_lane_steer #(.RAM_AW(RAM_AW)) u_steer (
		.core_req  (core_req),
		.con_addr  (con_addr),
		.con_strb  (con_strb),
		.con_wdata (con_wdata),
		.con_we    (con_we),
		.a_addr    (a_addr),
		.b_addr    (b_addr),
		.a_lane_wr (a_lane_wr),
		.b_lane_wr (b_lane_wr)
	);

	// One bank per byte lane
	for (genvar i = 0; i < dmem_pkg::LANES; i++) begin : g_lane
		byte_lane_ram #(.RAM_AW(RAM_AW)) u_bank (
			.clk     (clk),
			.a_addr  (a_addr),
			.a_wr    (a_lane_wr[i]),
			.a_rdata (a_lane_rdata[i]),
			.b_addr  (b_addr),
			.b_wr    (b_lane_wr[i]),
			.b_rdata (b_lane_rdata[i])
		);
	end

	load_lane_merge u_merge (
		.clk          (clk),
		.nrst         (nrst),
		.core_addr    (core_req.addr),
		.a_lane_rdata (a_lane_rdata),
		.b_lane_rdata (b_lane_rdata),
		.io_btn       (io_btn),
		.io_sw        (io_sw),
		.io_led       (io_led),
		.core_rdata   (core_rdata),
		.con_rdata    (con_rdata)
	);

	fpga_io_regs u_io (
		.clk      (clk),
		.nrst     (nrst),
		.btn      (btn),
		.sw       (sw),
		.core_req (core_req),
		.io_btn   (io_btn),
		.io_sw    (io_sw),
		.io_led   (io_led),
		.led      (led)
	);

endmodule

// ==== rtl/fpga_io_regs.sv ====
`timescale 1ns/1ps

module fpga_io_regs (
	input  logic                  clk,
	input  logic                  nrst,

	// Board inputs
	input  logic [3:0]            btn,
	input  logic [2:0]            sw,

	// Core request, checked for LED stores
	input  dmem_pkg::core_req_t   core_req,

	output dmem_pkg::word_t       io_btn,
	output dmem_pkg::word_t       io_sw,
	output dmem_pkg::word_t       io_led,
	output logic [3:0]            led
);

	logic led_we;

	// Store aimed at the LED word with a proper strobe
	assign led_we = (core_req.addr == dmem_pkg::IO_LED_IDX) &&
		dmem_pkg::strb_legal(core_req.strb);

	// Buttons and switches sampled every cycle
	// Zero extended to a full word
	always_ff @(posedge clk) begin
		if (!nrst) begin
			io_btn <= '0;
			io_sw  <= '0;
		end else begin
			io_btn <= {28'h0, btn};
			io_sw  <= {29'h0, sw};
		end
	end

	// LED word, byte writable
	always_ff @(posedge clk) begin
		if (!nrst) begin
			io_led <= '0;
		end else if (led_we) begin
			for (int i = 0; i < dmem_pkg::LANES; i++) begin
				// Only strobed bytes change
				if (core_req.strb[i]) begin
					io_led[8*i +: 8] <= core_req.wdata[8*i +: 8];
				end
			end
		end
	end

	// Board has four LEDs
	assign led = io_led[3:0];

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Compile with Verilator, run from the project root, look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_datamem -f build.f || exit 1
out=$(./obj_dir/Vtb_datamem)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qF '*** TEST PASSED ***' && exit 0 || exit 1
